// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_lookup_engine
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/action_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module action_ram
    import lookup_pkg::*;
#(
    parameter int ACT_W = 96
) (
    input  logic             clk,
    input  logic [IDX_W-1:0] rd_addr,
    output logic [ACT_W-1:0] rd_action,
    table_write_if.act_table wr
);

    logic [ACT_W-1:0] mem [TABLE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.act_wr_en) begin
            mem[wr.act_index] <= wr.act_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_action <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/ctrl_parser.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_parser
    import lookup_pkg::*;
#(
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   c_s_tvalid,
    input  logic                   c_s_tlast,
    input  logic [CTRL_W-1:0]      c_s_tdata,
    input  logic [CTRL_KEEP_W-1:0] c_s_tkeep,
    input  logic [CTRL_USER_W-1:0] c_s_tuser,
    output logic                   c_m_tvalid,
    output logic                   c_m_tlast,
    output logic [CTRL_W-1:0]      c_m_tdata,
    output logic [CTRL_KEEP_W-1:0] c_m_tkeep,
    output logic [CTRL_USER_W-1:0] c_m_tuser,
    table_write_if.parser          wr
);

    localparam int KEY_W     = $bits(wr.key_data);
    localparam int ACT_W     = $bits(wr.act_data);
    // second beat of a pair carries only what is left below the top CTRL_W bits
    localparam int ACT_LOW_W = ACT_W - CTRL_W;

    ctrl_state_t      state;
    logic [IDX_W-1:0] run_idx;

    logic [7:0]       hdr_mod;
    entry_kind_t      hdr_kind;
    logic [15:0]      hdr_flag;
    logic             hdr_hit;

    logic             at_header;
    logic             fwd_beat;
    logic             key_beat;
    logic             high_beat;
    logic             low_beat;

    // header decode, only meaningful in idle
    assign hdr_mod  = c_s_tdata[HDR_MOD_POS +: 8];
    assign hdr_kind = entry_kind_t'(c_s_tdata[HDR_KIND_POS +: 4]);
    assign hdr_flag = c_s_tdata[HDR_FLAG_POS +: 16];
    assign hdr_hit  = (hdr_mod[7:3] == 5'(STAGE_ID)) &&
                      (hdr_mod[2:0] == 3'(LOOKUP_ID)) &&
                      (hdr_flag == CTRL_FLAG);

    assign at_header = c_s_tvalid && (state == CTRL_IDLE);
    assign fwd_beat  = (at_header && !hdr_hit) || (c_s_tvalid && state == CTRL_FORWARD);
    assign key_beat  = c_s_tvalid && (state == CTRL_KEY);
    assign high_beat = c_s_tvalid && (state == CTRL_ACT_HIGH);
    assign low_beat  = c_s_tvalid && (state == CTRL_ACT_LOW);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= CTRL_IDLE;
            run_idx       <= '0;
            wr.key_wr_en  <= 1'b0;
            wr.act_wr_en  <= 1'b0;
            c_m_tvalid    <= 1'b0;
        end else begin
            // strobes follow the sampled beat by one cycle
            wr.key_wr_en <= key_beat;
            wr.act_wr_en <= low_beat;
            c_m_tvalid   <= fwd_beat;

            if (at_header && hdr_hit) begin
                run_idx <= c_s_tdata[HDR_INDEX_POS +: IDX_W];
            end else if (key_beat || low_beat) begin
                // wraps modulo the table depth
                run_idx <= run_idx + 1'b1;
            end

            case (state)
                CTRL_IDLE: begin
                    if (c_s_tvalid && !c_s_tlast) begin
                        if (!hdr_hit) begin
                            state <= CTRL_FORWARD;
                        end else if (hdr_kind == ENTRY_KEY) begin
                            state <= CTRL_KEY;
                        end else begin
                            state <= CTRL_ACT_HIGH;
                        end
                    end
                end
                CTRL_KEY: begin
                    if (c_s_tvalid && c_s_tlast) begin
                        state <= CTRL_IDLE;
                    end
                end
                CTRL_ACT_HIGH: begin
                    if (c_s_tvalid) begin
                        state <= c_s_tlast ? CTRL_DRAIN : CTRL_ACT_LOW;
                    end
                end
                CTRL_ACT_LOW: begin
                    if (c_s_tvalid) begin
                        state <= c_s_tlast ? CTRL_IDLE : CTRL_ACT_HIGH;
                    end
                end
                CTRL_FORWARD: begin
                    if (c_s_tvalid && c_s_tlast) begin
                        state <= CTRL_IDLE;
                    end
                end
                // lone high half at the end of the packet, nothing to write
                CTRL_DRAIN: state <= CTRL_IDLE;
                default:    state <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (key_beat) begin
            wr.key_index <= run_idx;
            wr.key_data  <= c_s_tdata[KEY_W-1:0];
        end
        if (high_beat) begin
            wr.act_data[ACT_W-1 -: CTRL_W] <= c_s_tdata;
        end
        if (low_beat) begin
            wr.act_index                <= run_idx;
            wr.act_data[ACT_LOW_W-1:0]  <= c_s_tdata[ACT_LOW_W-1:0];
        end
        if (fwd_beat) begin
            c_m_tdata <= c_s_tdata;
            c_m_tkeep <= c_s_tkeep;
            c_m_tuser <= c_s_tuser;
            c_m_tlast <= c_s_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lookup_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module lookup_engine
    import lookup_pkg::*;
#(
    parameter int KEY_W     = 32,
    parameter int ACT_W     = 96,
    parameter int PHV_W     = 64,
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // lookup side
    input  logic                   key_valid,
    input  logic [KEY_W-1:0]       key,
    input  logic [KEY_W-1:0]       mask,
    input  logic [PHV_W-1:0]       phv_in,
    output logic                   ready_out,
    output logic                   action_valid,
    output logic [ACT_W-1:0]       action,
    output logic [PHV_W-1:0]       phv_out,
    input  logic                   ready_in,

    // control stream in
    input  logic                   c_s_tvalid,
    input  logic                   c_s_tlast,
    input  logic [CTRL_W-1:0]      c_s_tdata,
    input  logic [CTRL_KEEP_W-1:0] c_s_tkeep,
    input  logic [CTRL_USER_W-1:0] c_s_tuser,

    // forwarded control stream
    output logic                   c_m_tvalid,
    output logic                   c_m_tlast,
    output logic [CTRL_W-1:0]      c_m_tdata,
    output logic [CTRL_KEEP_W-1:0] c_m_tkeep,
    output logic [CTRL_USER_W-1:0] c_m_tuser
);

    logic [KEY_W-1:0] held_key;
    logic [KEY_W-1:0] held_mask;
    logic             match;
    logic [IDX_W-1:0] match_addr;
    logic [ACT_W-1:0] rd_action;

    table_write_if #(.KEY_W(KEY_W), .ACT_W(ACT_W)) tbl_wr ();

    ctrl_parser #(.STAGE_ID(STAGE_ID), .LOOKUP_ID(LOOKUP_ID)) i_ctrl_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_s_tvalid (c_s_tvalid),
        .c_s_tlast  (c_s_tlast),
        .c_s_tdata  (c_s_tdata),
        .c_s_tkeep  (c_s_tkeep),
        .c_s_tuser  (c_s_tuser),
        .c_m_tvalid (c_m_tvalid),
        .c_m_tlast  (c_m_tlast),
        .c_m_tdata  (c_m_tdata),
        .c_m_tkeep  (c_m_tkeep),
        .c_m_tuser  (c_m_tuser),
        .wr         (tbl_wr)
    );

    match_table #(.KEY_W(KEY_W)) i_match_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmp_key    (held_key),
        .cmp_mask   (held_mask),
        .match      (match),
        .match_addr (match_addr),
        .wr         (tbl_wr)
    );

    action_ram #(.ACT_W(ACT_W)) i_action_ram (
        .clk       (clk),
        .rd_addr   (match_addr),
        .rd_action (rd_action),
        .wr        (tbl_wr)
    );

    lookup_fsm #(.KEY_W(KEY_W), .ACT_W(ACT_W), .PHV_W(PHV_W)) i_lookup_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key          (key),
        .mask         (mask),
        .phv_in       (phv_in),
        .ready_in     (ready_in),
        .match        (match),
        .rd_action    (rd_action),
        .ready_out    (ready_out),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out),
        .held_key     (held_key),
        .held_mask    (held_mask)
    );

endmodule

`default_nettype wire

// ==== hw/lookup_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module lookup_fsm
    import lookup_pkg::*;
#(
    parameter int KEY_W = 32,
    parameter int ACT_W = 96,
    parameter int PHV_W = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             key_valid,
    input  logic [KEY_W-1:0] key,
    input  logic [KEY_W-1:0] mask,
    input  logic [PHV_W-1:0] phv_in,
    input  logic             ready_in,
    input  logic             match,
    input  logic [ACT_W-1:0] rd_action,
    output logic             ready_out,
    output logic             action_valid,
    output logic [ACT_W-1:0] action,
    output logic [PHV_W-1:0] phv_out,
    output logic [KEY_W-1:0] held_key,
    output logic [KEY_W-1:0] held_mask
);

    lookup_state_t    state;
    logic [PHV_W-1:0] phv_hold;

    logic             capture;
    logic             miss_done;
    logic             hit_done;

    assign capture   = (state == LOOKUP_IDLE) && key_valid;
    // a miss goes out without looking at ready_in
    assign miss_done = (state == LOOKUP_MATCH_CHECK) && !match;
    assign hit_done  = ((state == LOOKUP_SEND) || (state == LOOKUP_HALT)) && ready_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LOOKUP_IDLE;
            ready_out    <= 1'b1;
            action_valid <= 1'b0;
        end else begin
            action_valid <= miss_done || hit_done;

            if (capture) begin
                ready_out <= 1'b0;
            end else if (miss_done || hit_done) begin
                ready_out <= 1'b1;
            end

            case (state)
                LOOKUP_IDLE: begin
                    if (key_valid) begin
                        state <= LOOKUP_MATCH_WAIT;
                    end
                end
                // table registers its compare result here
                LOOKUP_MATCH_WAIT:  state <= LOOKUP_MATCH_CHECK;
                LOOKUP_MATCH_CHECK: state <= match ? LOOKUP_SEND : LOOKUP_IDLE;
                LOOKUP_SEND:        state <= ready_in ? LOOKUP_IDLE : LOOKUP_HALT;
                LOOKUP_HALT: begin
                    if (ready_in) begin
                        state <= LOOKUP_IDLE;
                    end
                end
                default: state <= LOOKUP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_key  <= key;
            held_mask <= mask;
            phv_hold  <= phv_in;
        end

        // held key is stable, so rd_action stays valid while halted
        if (miss_done) begin
            action <= ACT_W'(DEFAULT_ACTION_CODE);
        end else if (hit_done) begin
            action <= rd_action;
        end

        if (miss_done || hit_done) begin
            phv_out <= phv_hold;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lookup_pkg.sv ====
`default_nettype none

package lookup_pkg;

    // control stream widths
    localparam int CTRL_W      = 64;
    localparam int CTRL_KEEP_W = 8;
    localparam int CTRL_USER_W = 16;

    // table geometry
    localparam int TABLE_DEPTH = 16;
    localparam int IDX_W       = 4;

    // header beat fields, given as the low bit of each field
    localparam int HDR_MOD_POS   = 56;
    localparam int HDR_KIND_POS  = 52;
    localparam int HDR_INDEX_POS = 48;
    localparam int HDR_FLAG_POS  = 32;

    localparam logic [15:0] CTRL_FLAG           = 16'hf2f1;
    localparam logic [7:0]  DEFAULT_ACTION_CODE = 8'h3f;

    // any non-zero kind is handled as an action entry
    typedef enum logic [3:0] {
        ENTRY_KEY    = 4'd0,
        ENTRY_ACTION = 4'd1
    } entry_kind_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_KEY,
        CTRL_ACT_HIGH,
        CTRL_ACT_LOW,
        CTRL_FORWARD,
        CTRL_DRAIN
    } ctrl_state_t;

    typedef enum logic [2:0] {
        LOOKUP_IDLE,
        LOOKUP_MATCH_WAIT,
        LOOKUP_MATCH_CHECK,
        LOOKUP_SEND,
        LOOKUP_HALT
    } lookup_state_t;

endpackage

`default_nettype wire

// ==== hw/match_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module match_table
    import lookup_pkg::*;
#(
    parameter int KEY_W = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [KEY_W-1:0] cmp_key,
    input  logic [KEY_W-1:0] cmp_mask,
    output logic             match,
    output logic [IDX_W-1:0] match_addr,
    table_write_if.key_table wr
);

    logic [KEY_W-1:0]       entry_key [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] entry_valid;
    logic [TABLE_DEPTH-1:0] hit;
    logic [IDX_W-1:0]       hit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr.key_wr_en) begin
            entry_valid[wr.key_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.key_wr_en) begin
            entry_key[wr.key_index] <= wr.key_data;
        end
    end

    // mask bit set means the key bit is a don't care
    always_comb begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            hit[i] = entry_valid[i] && (((entry_key[i] ^ cmp_key) & ~cmp_mask) == '0);
        end
    end

    // lowest index wins, so scan downwards
    always_comb begin
        hit_idx = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match      <= 1'b0;
            match_addr <= '0;
        end else begin
            match      <= |hit;
            match_addr <= hit_idx;
        end
    end

endmodule

`default_nettype wire

// ==== hw/table_write_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface table_write_if
    import lookup_pkg::*;
#(
    parameter int KEY_W = 32,
    parameter int ACT_W = 96
);

    // key table write port
    logic             key_wr_en;
    logic [IDX_W-1:0] key_index;
    logic [KEY_W-1:0] key_data;

    // action table write port
    logic             act_wr_en;
    logic [IDX_W-1:0] act_index;
    logic [ACT_W-1:0] act_data;

    modport parser (
        output key_wr_en, key_index, key_data,
        output act_wr_en, act_index, act_data
    );

    modport key_table (input key_wr_en, key_index, key_data);

    modport act_table (input act_wr_en, act_index, act_data);

endinterface

`default_nettype wire

// ==== sources.f ====
hw/lookup_pkg.sv
hw/table_write_if.sv
hw/ctrl_parser.sv
hw/match_table.sv
hw/action_ram.sv
hw/lookup_fsm.sv
hw/lookup_engine.sv
verification/tb_lookup_engine.sv

// ==== verification/tb_lookup_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lookup_engine
    import lookup_pkg::*;
();

    // roughly 120 cycles of traffic, the rest is margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [95:0] MISS_ACTION = 96'h3f;
    localparam logic [7:0]  OWN_MOD     = 8'h02;

    logic                   clk;
    logic                   rst_n;
    logic                   key_valid;
    logic [31:0]            key;
    logic [31:0]            mask;
    logic [63:0]            phv_in;
    logic                   ready_in;
    logic                   ready_out;
    logic                   action_valid;
    logic [95:0]            action;
    logic [63:0]            phv_out;
    logic                   c_s_tvalid;
    logic                   c_s_tlast;
    logic [CTRL_W-1:0]      c_s_tdata;
    logic [CTRL_KEEP_W-1:0] c_s_tkeep;
    logic [CTRL_USER_W-1:0] c_s_tuser;
    logic                   c_m_tvalid;
    logic                   c_m_tlast;
    logic [CTRL_W-1:0]      c_m_tdata;
    logic [CTRL_KEEP_W-1:0] c_m_tkeep;
    logic [CTRL_USER_W-1:0] c_m_tuser;

    int          seed;
    int          errors;
    int          checks;
    int          tests;
    int unsigned cycle = 0;

    logic [31:0] keys [16];
    logic [95:0] acts [16];

    // packet being built, then what went in and what came out
    logic [63:0] pkt_data [$];
    logic [7:0]  pkt_keep [$];
    logic [15:0] pkt_user [$];
    logic [63:0] in_data [$];
    logic [7:0]  in_keep [$];
    logic [15:0] in_user [$];
    logic        in_last [$];
    int          in_time [$];
    logic [63:0] out_data [$];
    logic [7:0]  out_keep [$];
    logic [15:0] out_user [$];
    logic        out_last [$];
    int          out_time [$];

    lookup_engine i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // forwarded beats, sampled mid cycle
    always @(negedge clk) begin
        if (c_m_tvalid) begin
            out_data.push_back(c_m_tdata);
            out_keep.push_back(c_m_tkeep);
            out_user.push_back(c_m_tuser);
            out_last.push_back(c_m_tlast);
            out_time.push_back(int'(cycle));
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand32();
        lo = rand32();
        return {hi, lo};
    endfunction

    function automatic logic [63:0] make_header(input logic [7:0] mod_id, input logic [3:0] kind,
                                                input logic [3:0] idx, input logic [15:0] flag);
        return {mod_id, kind, idx, flag, 32'h0};
    endfunction

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%s: %s, %0d errors", name, (errors == err0) ? "ok" : "errors found",
                 errors - err0);
    endtask

    task automatic settle();
        repeat (3) @(posedge clk);
    endtask

    task automatic pkt_clear();
        pkt_data.delete();
        pkt_keep.delete();
        pkt_user.delete();
    endtask

    task automatic pkt_add(input logic [63:0] data, input logic [7:0] keep,
                           input logic [15:0] user);
        pkt_data.push_back(data);
        pkt_keep.push_back(keep);
        pkt_user.push_back(user);
    endtask

    task automatic send_packet();
        in_data.delete();
        in_keep.delete();
        in_user.delete();
        in_last.delete();
        in_time.delete();
        out_data.delete();
        out_keep.delete();
        out_user.delete();
        out_last.delete();
        out_time.delete();
        for (int i = 0; i < pkt_data.size(); i++) begin
            @(posedge clk);
            c_s_tvalid <= 1'b1;
            c_s_tdata  <= pkt_data[i];
            c_s_tkeep  <= pkt_keep[i];
            c_s_tuser  <= pkt_user[i];
            c_s_tlast  <= (i == pkt_data.size() - 1);
            @(negedge clk);
            in_data.push_back(pkt_data[i]);
            in_keep.push_back(pkt_keep[i]);
            in_user.push_back(pkt_user[i]);
            in_last.push_back(i == pkt_data.size() - 1);
            in_time.push_back(int'(cycle));
        end
        @(posedge clk);
        c_s_tvalid <= 1'b0;
        c_s_tlast  <= 1'b0;
    endtask

    task automatic check_forwarded(input string name);
        check_true(out_data.size() == in_data.size(),
                   {name, ": number of forwarded beats differs from beats sent"});
        for (int i = 0; i < in_data.size() && i < out_data.size(); i++) begin
            check_val("c_m_tdata", 128'(out_data[i]), 128'(in_data[i]));
            check_val("c_m_tkeep", 128'(out_keep[i]), 128'(in_keep[i]));
            check_val("c_m_tuser", 128'(out_user[i]), 128'(in_user[i]));
            check_val("c_m_tlast", 128'(out_last[i]), 128'(in_last[i]));
            check_val("forward delay", 128'(out_time[i] - in_time[i]), 128'(1));
        end
    endtask

    // drives through the capture edge and returns right after it
    task automatic start_lookup(input logic [31:0] k, input logic [31:0] m,
                                input logic [63:0] p);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_out && n < 50) begin
            @(negedge clk);
            n++;
        end
        check_true(ready_out, "ready_out stayed low before a lookup");
        @(posedge clk);
        key_valid <= 1'b1;
        key       <= k;
        mask      <= m;
        phv_in    <= p;
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    // edges counted from the current one until action_valid is seen
    task automatic wait_result(output int edges);
        edges = -1;
        for (int i = 1; i <= 20; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (action_valid) begin
                edges = i;
                break;
            end
        end
        check_true(edges > 0, "action_valid did not rise after a lookup");
    endtask

    task automatic check_result(input logic [95:0] exp_act, input logic [63:0] p);
        check_val("action", 128'(action), 128'(exp_act));
        check_val("phv_out", 128'(phv_out), 128'(p));
        check_val("ready_out", 128'(ready_out), 128'(1));
        @(negedge clk);
        // single cycle pulse, data held afterwards
        check_val("action_valid", 128'(action_valid), 128'(0));
        check_val("action", 128'(action), 128'(exp_act));
        check_val("phv_out", 128'(phv_out), 128'(p));
    endtask

    task automatic check_lookup(input logic [31:0] k, input logic [31:0] m,
                                input logic [95:0] exp_act, input int exp_edges);
        logic [63:0] p;
        int          edges;
        p = rand64();
        start_lookup(k, m, p);
        wait_result(edges);
        check_val("lookup latency", 128'(edges), 128'(exp_edges));
        check_result(exp_act, p);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_val("ready_out", 128'(ready_out), 128'(1));
        check_val("action_valid", 128'(action_valid), 128'(0));
        check_val("c_m_tvalid", 128'(c_m_tvalid), 128'(0));
        // full mask, so any entry left valid would hit
        check_lookup(rand32(), 32'hffff_ffff, MISS_ACTION, 2);
        report_test("reset and empty table", err0);
    endtask

    task automatic test_program();
        int          err0;
        logic [31:0] r;
        logic [63:0] junk;
        err0 = errors;
        r = rand32();
        keys[5] = {8'h5a, r[23:0]};
        r = rand32();
        keys[6] = {8'ha5, r[23:0]};
        keys[7] = keys[6] ^ 32'h0000_00f0;
        for (int i = 5; i <= 7; i++) begin
            acts[i] = {rand64(), rand32()};
        end

        pkt_clear();
        pkt_add(make_header(OWN_MOD, 4'h0, 4'd5, 16'hf2f1), 8'hff, 16'h0);
        for (int i = 5; i <= 7; i++) begin
            junk = rand64();
            pkt_add({junk[63:32], keys[i]}, 8'hff, 16'h0);
        end
        send_packet();
        settle();
        check_true(out_data.size() == 0, "key packet showed up on the c_m outputs");

        pkt_clear();
        pkt_add(make_header(OWN_MOD, 4'h1, 4'd5, 16'hf2f1), 8'hff, 16'h0);
        for (int i = 5; i <= 7; i++) begin
            junk = rand64();
            pkt_add(acts[i][95:32], 8'hff, 16'h0);
            pkt_add({junk[63:32], acts[i][31:0]}, 8'hff, 16'h0);
        end
        send_packet();
        settle();
        check_true(out_data.size() == 0, "action packet showed up on the c_m outputs");

        for (int i = 5; i <= 7; i++) begin
            check_lookup(keys[i], 32'h0, acts[i], 3);
        end
        report_test("programming and hits", err0);
    endtask

    task automatic test_mask();
        int          err0;
        logic [31:0] r;
        err0 = errors;
        check_lookup(keys[5] ^ 32'h0000_0f0f, 32'h0000_0f0f, acts[5], 3);
        // entries 6 and 7 both match, lower index wins
        check_lookup(keys[6], 32'h0000_00f0, acts[6], 3);
        r = rand32();
        check_lookup({8'hc3, r[23:0]}, 32'h0000_00ff, MISS_ACTION, 2);
        report_test("mask and priority", err0);
    endtask

    task automatic test_backpressure();
        int          err0;
        int          edges;
        logic [63:0] p;
        err0 = errors;
        p = rand64();
        @(posedge clk);
        ready_in <= 1'b0;
        start_lookup(keys[7], 32'h0, p);
        repeat (8) begin
            @(negedge clk);
            check_val("action_valid", 128'(action_valid), 128'(0));
            check_val("ready_out", 128'(ready_out), 128'(0));
        end
        @(posedge clk);
        ready_in <= 1'b1;
        wait_result(edges);
        check_val("release latency", 128'(edges), 128'(1));
        check_result(acts[7], p);
        report_test("back-pressure", err0);
    endtask

    task automatic send_foreign(input logic [7:0] mod_id, input logic [15:0] flag);
        logic [31:0] r;
        logic [63:0] hdr;
        pkt_clear();
        r = rand32();
        hdr = make_header(mod_id, 4'h0, 4'd3, flag);
        pkt_add({hdr[63:32], r}, r[7:0], r[23:8]);
        repeat (2) begin
            r = rand32();
            pkt_add(rand64(), r[7:0], r[23:8]);
        end
        send_packet();
        settle();
    endtask

    task automatic test_forward();
        int          err0;
        logic [63:0] junk;
        err0 = errors;
        // stage id 1 instead of 0
        send_foreign(8'h0a, 16'hf2f1);
        check_forwarded("wrong stage id");
        send_foreign(8'h03, 16'hf2f1);
        check_forwarded("wrong lookup id");
        send_foreign(OWN_MOD, 16'hf2f0);
        check_forwarded("wrong flag");

        pkt_clear();
        junk = rand64();
        pkt_add(make_header(OWN_MOD, 4'h0, 4'd12, 16'hf2f1), 8'hff, 16'h0);
        pkt_add(junk, 8'hff, 16'h0);
        send_packet();
        settle();
        check_true(out_data.size() == 0, "own packet produced c_m_tvalid");
        report_test("forwarding", err0);
    endtask

    initial begin
        seed   = 94;
        errors = 0;
        checks = 0;
        tests  = 0;

        rst_n      = 1'b0;
        key_valid  = 1'b0;
        key        = '0;
        mask       = '0;
        phv_in     = '0;
        ready_in   = 1'b1;
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
        c_s_tdata  = '0;
        c_s_tkeep  = '0;
        c_s_tuser  = '0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_program();
        test_mask();
        test_backpressure();
        test_forward();

        settle();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
